//--- Bender.yml
package:
  name: dma_core

sources:
  - logic/dma_pkg.sv
  - logic/dma_reg_frontend.sv
  - logic/dma_job_fifo.sv
  - logic/dma_nd_midend.sv
  - logic/dma_backend.sv
  - logic/dma_core_top.sv
  - target: test
    files:
      - verif/dma_core_assert.sv
      - verif/dma_core_tb.sv

//--- build.f
logic/dma_pkg.sv
logic/dma_reg_frontend.sv
logic/dma_job_fifo.sv
logic/dma_nd_midend.sv
logic/dma_backend.sv
logic/dma_core_top.sv
verif/dma_core_assert.sv
verif/dma_core_tb.sv

//--- logic/dma_backend.sv
/*
 * Word-by-word copy over a request/grant memory port, one access at a time.
 * Addresses step by DataWidth/8; no byte strobes. Zero-length bursts skip memory.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_backend #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 burst_valid_i,
  output logic                 burst_ready_o,
  input  logic [AddrWidth-1:0] burst_src_i,
  input  logic [AddrWidth-1:0] burst_dst_i,
  input  logic [AddrWidth-1:0] burst_len_i,
  output logic                 burst_done_o,
  output logic                 busy_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic [AddrWidth-1:0] mem_addr_o,
  output logic [DataWidth-1:0] mem_wdata_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  logic [DataWidth-1:0] mem_rdata_i
);
  import dma_pkg::*;

  localparam logic [AddrWidth-1:0] WordBytes = AddrWidth'(DataWidth / 8);

  be_state_e            state_q;
  be_state_e            state_d;
  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  logic [AddrWidth-1:0] left_q;
  logic [DataWidth-1:0] data_q;
  logic                 done_q;
  logic                 accept;
  logic                 wr_gnt;

  assign burst_ready_o = (state_q == BE_IDLE);
  assign accept        = burst_valid_i && burst_ready_o;
  assign wr_gnt        = (state_q == BE_WRITE) && mem_gnt_i;

  assign mem_req_o    = (state_q == BE_READ) || (state_q == BE_WRITE);
  assign mem_we_o     = (state_q == BE_WRITE);
  assign mem_addr_o   = mem_we_o ? dst_q : src_q;
  assign mem_wdata_o  = data_q;
  assign burst_done_o = done_q;
  assign busy_o       = (state_q != BE_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      BE_IDLE: begin
        if (accept) begin
          state_d = (burst_len_i == '0) ? BE_DONE : BE_READ;
        end
      end
      BE_READ:   if (mem_gnt_i) state_d = BE_WAIT_R;
      BE_WAIT_R: if (mem_rvalid_i) state_d = BE_WRITE;
      BE_WRITE: begin
        if (mem_gnt_i) begin
          state_d = (left_q == AddrWidth'(1)) ? BE_DONE : BE_READ;
        end
      end
      BE_DONE:   state_d = BE_IDLE;
      default:   state_d = BE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BE_IDLE;
      left_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Pulse in the cycle after DONE
      done_q  <= (state_q == BE_DONE);
      if (accept) begin
        left_q <= burst_len_i;
      end else if (wr_gnt) begin
        left_q <= left_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q <= burst_src_i;
      dst_q <= burst_dst_i;
    end else if (wr_gnt) begin
      src_q <= src_q + WordBytes;
      dst_q <= dst_q + WordBytes;
    end
    if ((state_q == BE_WAIT_R) && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

endmodule : dma_backend

`default_nettype wire

//--- logic/dma_core_top.sv
/*
 * DMA core: register frontend, job FIFO, 2D midend and copy backend.
 * Memory port is word granular with one access outstanding. JobFifoDepth >= 2.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_core_top #(
  parameter int unsigned AddrWidth    = 32,
  parameter int unsigned DataWidth    = 32,
  parameter int unsigned JobFifoDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 reg_req_i,
  input  logic                 reg_we_i,
  input  logic [3:0]           reg_addr_i,
  input  logic [DataWidth-1:0] reg_wdata_i,
  output logic [DataWidth-1:0] reg_rdata_o,
  output logic                 reg_ready_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic [AddrWidth-1:0] mem_addr_o,
  output logic [DataWidth-1:0] mem_wdata_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  logic [DataWidth-1:0] mem_rdata_i
);

  // Frontend to FIFO
  logic                 fe_valid;
  logic                 fe_ready;
  logic [AddrWidth-1:0] fe_src;
  logic [AddrWidth-1:0] fe_dst;
  logic [AddrWidth-1:0] fe_len;
  logic [AddrWidth-1:0] fe_src_stride;
  logic [AddrWidth-1:0] fe_dst_stride;
  logic [AddrWidth-1:0] fe_reps;

  // FIFO to midend
  logic                 job_valid;
  logic                 job_ready;
  logic [AddrWidth-1:0] job_src;
  logic [AddrWidth-1:0] job_dst;
  logic [AddrWidth-1:0] job_len;
  logic [AddrWidth-1:0] job_src_stride;
  logic [AddrWidth-1:0] job_dst_stride;
  logic [AddrWidth-1:0] job_reps;

  // Midend to backend
  logic                 burst_valid;
  logic                 burst_ready;
  logic [AddrWidth-1:0] burst_src;
  logic [AddrWidth-1:0] burst_dst;
  logic [AddrWidth-1:0] burst_len;
  logic                 burst_done;

  logic                 job_done;
  logic                 mid_busy;
  logic                 be_busy;

  dma_reg_frontend #(
    .AddrWidth ( AddrWidth ),
    .DataWidth ( DataWidth )
  ) i_reg_frontend (
    .clk_i,
    .arst_n_i,
    .reg_req_i,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_ready_o,
    .job_valid_o      ( fe_valid            ),
    .job_ready_i      ( fe_ready            ),
    .job_src_o        ( fe_src              ),
    .job_dst_o        ( fe_dst              ),
    .job_len_o        ( fe_len              ),
    .job_src_stride_o ( fe_src_stride       ),
    .job_dst_stride_o ( fe_dst_stride       ),
    .job_reps_o       ( fe_reps             ),
    .job_done_i       ( job_done            ),
    .busy_i           ( mid_busy | be_busy  )
  );

  dma_job_fifo #(
    .AddrWidth    ( AddrWidth    ),
    .JobFifoDepth ( JobFifoDepth )
  ) i_job_fifo (
    .clk_i,
    .arst_n_i,
    .push_valid_i      ( fe_valid       ),
    .push_ready_o      ( fe_ready       ),
    .push_src_i        ( fe_src         ),
    .push_dst_i        ( fe_dst         ),
    .push_len_i        ( fe_len         ),
    .push_src_stride_i ( fe_src_stride  ),
    .push_dst_stride_i ( fe_dst_stride  ),
    .push_reps_i       ( fe_reps        ),
    .pop_valid_o       ( job_valid      ),
    .pop_ready_i       ( job_ready      ),
    .pop_src_o         ( job_src        ),
    .pop_dst_o         ( job_dst        ),
    .pop_len_o         ( job_len        ),
    .pop_src_stride_o  ( job_src_stride ),
    .pop_dst_stride_o  ( job_dst_stride ),
    .pop_reps_o        ( job_reps       )
  );

  dma_nd_midend #(
    .AddrWidth ( AddrWidth )
  ) i_nd_midend (
    .clk_i,
    .arst_n_i,
    .job_valid_i      ( job_valid      ),
    .job_ready_o      ( job_ready      ),
    .job_src_i        ( job_src        ),
    .job_dst_i        ( job_dst        ),
    .job_len_i        ( job_len        ),
    .job_src_stride_i ( job_src_stride ),
    .job_dst_stride_i ( job_dst_stride ),
    .job_reps_i       ( job_reps       ),
    .burst_valid_o    ( burst_valid    ),
    .burst_ready_i    ( burst_ready    ),
    .burst_src_o      ( burst_src      ),
    .burst_dst_o      ( burst_dst      ),
    .burst_len_o      ( burst_len      ),
    .burst_done_i     ( burst_done     ),
    .job_done_o       ( job_done       ),
    .busy_o           ( mid_busy       )
  );

  dma_backend #(
    .AddrWidth ( AddrWidth ),
    .DataWidth ( DataWidth )
  ) i_backend (
    .clk_i,
    .arst_n_i,
    .burst_valid_i ( burst_valid ),
    .burst_ready_o ( burst_ready ),
    .burst_src_i   ( burst_src   ),
    .burst_dst_i   ( burst_dst   ),
    .burst_len_i   ( burst_len   ),
    .burst_done_o  ( burst_done  ),
    .busy_o        ( be_busy     ),
    .mem_req_o,
    .mem_we_o,
    .mem_addr_o,
    .mem_wdata_o,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i
  );

endmodule : dma_core_top

`default_nettype wire

//--- logic/dma_job_fifo.sv
/*
 * Job queue, not fall-through: a pushed job shows on the output one cycle later.
 * JobFifoDepth must be at least 2.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_job_fifo #(
  parameter int unsigned AddrWidth    = 32,
  parameter int unsigned JobFifoDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 push_valid_i,
  output logic                 push_ready_o,
  input  logic [AddrWidth-1:0] push_src_i,
  input  logic [AddrWidth-1:0] push_dst_i,
  input  logic [AddrWidth-1:0] push_len_i,
  input  logic [AddrWidth-1:0] push_src_stride_i,
  input  logic [AddrWidth-1:0] push_dst_stride_i,
  input  logic [AddrWidth-1:0] push_reps_i,
  output logic                 pop_valid_o,
  input  logic                 pop_ready_i,
  output logic [AddrWidth-1:0] pop_src_o,
  output logic [AddrWidth-1:0] pop_dst_o,
  output logic [AddrWidth-1:0] pop_len_o,
  output logic [AddrWidth-1:0] pop_src_stride_o,
  output logic [AddrWidth-1:0] pop_dst_stride_o,
  output logic [AddrWidth-1:0] pop_reps_o
);

  localparam int unsigned PtrWidth = $clog2(JobFifoDepth);
  localparam int unsigned CntWidth = $clog2(JobFifoDepth + 1);

  logic [AddrWidth-1:0] src_mem        [JobFifoDepth];
  logic [AddrWidth-1:0] dst_mem        [JobFifoDepth];
  logic [AddrWidth-1:0] len_mem        [JobFifoDepth];
  logic [AddrWidth-1:0] src_stride_mem [JobFifoDepth];
  logic [AddrWidth-1:0] dst_stride_mem [JobFifoDepth];
  logic [AddrWidth-1:0] reps_mem       [JobFifoDepth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 push;
  logic                 pop;

  // Wraps for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] ptr_next(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(JobFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CntWidth'(JobFifoDepth));
  assign pop_valid_o  = (count_q != '0);
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;

  assign pop_src_o        = src_mem[rd_ptr_q];
  assign pop_dst_o        = dst_mem[rd_ptr_q];
  assign pop_len_o        = len_mem[rd_ptr_q];
  assign pop_src_stride_o = src_stride_mem[rd_ptr_q];
  assign pop_dst_stride_o = dst_stride_mem[rd_ptr_q];
  assign pop_reps_o       = reps_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      src_mem[wr_ptr_q]        <= push_src_i;
      dst_mem[wr_ptr_q]        <= push_dst_i;
      len_mem[wr_ptr_q]        <= push_len_i;
      src_stride_mem[wr_ptr_q] <= push_src_stride_i;
      dst_stride_mem[wr_ptr_q] <= push_dst_stride_i;
      reps_mem[wr_ptr_q]       <= push_reps_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule : dma_job_fifo

`default_nettype wire

//--- logic/dma_nd_midend.sv
/*
 * Expands a two-dimensional job into one burst per repetition.
 * Only one burst is in flight; a reps value of 0 runs once.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_nd_midend #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 job_valid_i,
  output logic                 job_ready_o,
  input  logic [AddrWidth-1:0] job_src_i,
  input  logic [AddrWidth-1:0] job_dst_i,
  input  logic [AddrWidth-1:0] job_len_i,
  input  logic [AddrWidth-1:0] job_src_stride_i,
  input  logic [AddrWidth-1:0] job_dst_stride_i,
  input  logic [AddrWidth-1:0] job_reps_i,
  output logic                 burst_valid_o,
  input  logic                 burst_ready_i,
  output logic [AddrWidth-1:0] burst_src_o,
  output logic [AddrWidth-1:0] burst_dst_o,
  output logic [AddrWidth-1:0] burst_len_o,
  input  logic                 burst_done_i,
  output logic                 job_done_o,
  output logic                 busy_o
);
  import dma_pkg::*;

  mid_state_e           state_q;
  mid_state_e           state_d;
  logic [AddrWidth-1:0] cur_src_q;
  logic [AddrWidth-1:0] cur_dst_q;
  logic [AddrWidth-1:0] len_q;
  logic [AddrWidth-1:0] src_stride_q;
  logic [AddrWidth-1:0] dst_stride_q;
  logic [AddrWidth-1:0] reps_left_q;
  logic                 job_done_q;
  logic                 accept;
  logic                 step;
  logic                 last;

  assign job_ready_o = (state_q == MID_IDLE);
  assign accept      = job_valid_i && job_ready_o;
  assign step        = (state_q == MID_WAIT) && burst_done_i;
  assign last        = (reps_left_q == AddrWidth'(1));

  assign burst_valid_o = (state_q == MID_ISSUE);
  assign burst_src_o   = cur_src_q;
  assign burst_dst_o   = cur_dst_q;
  assign burst_len_o   = len_q;
  assign job_done_o    = job_done_q;
  assign busy_o        = (state_q != MID_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      MID_IDLE:  if (accept) state_d = MID_ISSUE;
      MID_ISSUE: if (burst_ready_i) state_d = MID_WAIT;
      MID_WAIT:  if (burst_done_i) state_d = last ? MID_IDLE : MID_ISSUE;
      default:   state_d = MID_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= MID_IDLE;
      reps_left_q <= '0;
      job_done_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      job_done_q <= step && last;
      if (accept) begin
        reps_left_q <= (job_reps_i == '0) ? AddrWidth'(1) : job_reps_i;
      end else if (step) begin
        reps_left_q <= reps_left_q - 1'b1;
      end
    end
  end

  // Running addresses move by one stride per finished burst
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_src_q    <= job_src_i;
      cur_dst_q    <= job_dst_i;
      len_q        <= job_len_i;
      src_stride_q <= job_src_stride_i;
      dst_stride_q <= job_dst_stride_i;
    end else if (step) begin
      cur_src_q <= cur_src_q + src_stride_q;
      cur_dst_q <= cur_dst_q + dst_stride_q;
    end
  end

endmodule : dma_nd_midend

`default_nettype wire

//--- logic/dma_pkg.sv
/*
 * Shared definitions for the DMA core.
 * Register offsets are word indices on the 4-bit register address.
 */
`default_nettype none

package dma_pkg;

  // Width of job identifiers and of the completion counter
  localparam int unsigned JobIdWidth = 16;

  typedef enum logic [3:0] {
    REG_SRC        = 4'd0,
    REG_DST        = 4'd1,
    REG_LEN        = 4'd2,
    REG_SRC_STRIDE = 4'd3,
    REG_DST_STRIDE = 4'd4,
    REG_REPS       = 4'd5,
    REG_NEXT_ID    = 4'd6,
    REG_DONE_ID    = 4'd7,
    REG_STATUS     = 4'd8
  } dma_reg_e;

  typedef enum logic [1:0] {
    MID_IDLE,
    MID_ISSUE,
    MID_WAIT
  } mid_state_e;

  typedef enum logic [2:0] {
    BE_IDLE,
    BE_READ,
    BE_WAIT_R,
    BE_WRITE,
    BE_DONE
  } be_state_e;

endpackage : dma_pkg

`default_nettype wire

//--- logic/dma_reg_frontend.sv
/*
 * Job registers behind a request/ready port. Reading NEXT_ID launches the job
 * currently held in the registers. DataWidth must be at least JobIdWidth.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_reg_frontend #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 reg_req_i,
  input  logic                 reg_we_i,
  input  logic [3:0]           reg_addr_i,
  input  logic [DataWidth-1:0] reg_wdata_i,
  output logic [DataWidth-1:0] reg_rdata_o,
  output logic                 reg_ready_o,
  output logic                 job_valid_o,
  input  logic                 job_ready_i,
  output logic [AddrWidth-1:0] job_src_o,
  output logic [AddrWidth-1:0] job_dst_o,
  output logic [AddrWidth-1:0] job_len_o,
  output logic [AddrWidth-1:0] job_src_stride_o,
  output logic [AddrWidth-1:0] job_dst_stride_o,
  output logic [AddrWidth-1:0] job_reps_o,
  input  logic                 job_done_i,
  input  logic                 busy_i
);
  import dma_pkg::*;

  dma_reg_e              reg_sel;
  logic                  launch_rd;
  logic                  wr_en;
  logic [JobIdWidth-1:0] next_id_q;
  logic [JobIdWidth-1:0] new_id;
  logic [JobIdWidth-1:0] done_id_q;

  assign reg_sel   = dma_reg_e'(reg_addr_i);
  assign wr_en     = reg_req_i && reg_we_i;
  assign launch_rd = reg_req_i && !reg_we_i && (reg_sel == REG_NEXT_ID);
  assign new_id    = next_id_q + 1'b1;

  // Launch stalls the port while the job FIFO is full
  assign reg_ready_o = !(launch_rd && !job_ready_i);
  assign job_valid_o = launch_rd;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      job_src_o        <= '0;
      job_dst_o        <= '0;
      job_len_o        <= '0;
      job_src_stride_o <= '0;
      job_dst_stride_o <= '0;
      job_reps_o       <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        REG_SRC:        job_src_o        <= AddrWidth'(reg_wdata_i);
        REG_DST:        job_dst_o        <= AddrWidth'(reg_wdata_i);
        REG_LEN:        job_len_o        <= AddrWidth'(reg_wdata_i);
        REG_SRC_STRIDE: job_src_stride_o <= AddrWidth'(reg_wdata_i);
        REG_DST_STRIDE: job_dst_stride_o <= AddrWidth'(reg_wdata_i);
        REG_REPS:       job_reps_o       <= AddrWidth'(reg_wdata_i);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      next_id_q <= '0;
      done_id_q <= '0;
    end else begin
      if (launch_rd && job_ready_i) begin
        next_id_q <= new_id;
      end
      if (job_done_i) begin
        done_id_q <= done_id_q + 1'b1;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_sel)
      REG_SRC:        reg_rdata_o = DataWidth'(job_src_o);
      REG_DST:        reg_rdata_o = DataWidth'(job_dst_o);
      REG_LEN:        reg_rdata_o = DataWidth'(job_len_o);
      REG_SRC_STRIDE: reg_rdata_o = DataWidth'(job_src_stride_o);
      REG_DST_STRIDE: reg_rdata_o = DataWidth'(job_dst_stride_o);
      REG_REPS:       reg_rdata_o = DataWidth'(job_reps_o);
      // Identifier the job gets if this read launches it
      REG_NEXT_ID:    reg_rdata_o = DataWidth'(new_id);
      REG_DONE_ID:    reg_rdata_o = DataWidth'(done_id_q);
      REG_STATUS:     reg_rdata_o = DataWidth'(busy_i);
      default: ;
    endcase
  end

endmodule : dma_reg_frontend

`default_nettype wire

//--- verif/dma_core_assert.sv
/*
 * Memory port checks, bound into dma_core_top.
 * Write data is compared with the latest rvalid data, one read outstanding.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_core_assert #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned DataWidth = 32
) (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 mem_req_o,
  input logic                 mem_we_o,
  input logic [AddrWidth-1:0] mem_addr_o,
  input logic [DataWidth-1:0] mem_wdata_o,
  input logic                 mem_gnt_i,
  input logic                 mem_rvalid_i,
  input logic [DataWidth-1:0] mem_rdata_i
);

  logic [DataWidth-1:0] last_rdata_q;
  int                   fail_count = 0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_rdata_q <= '0;
    end else if (mem_rvalid_i) begin
      last_rdata_q <= mem_rdata_i;
    end
  end

  req_stable_until_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
      && $stable(mem_wdata_o))
    else begin
      $error("memory request changed before its grant");
      fail_count++;
    end

  req_low_after_reset: assert property (@(posedge clk_i)
    !$past(arst_n_i) |-> !mem_req_o)
    else begin
      $error("memory request high during or right after reset");
      fail_count++;
    end

  wdata_is_read_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && mem_we_o |-> mem_wdata_o == last_rdata_q)
    else begin
      $error("write data differs from the last read data");
      fail_count++;
    end

endmodule : dma_core_assert

bind dma_core_top dma_core_assert #(
  .AddrWidth ( AddrWidth ),
  .DataWidth ( DataWidth )
) u_dma_core_assert (
  .clk_i,
  .arst_n_i,
  .mem_req_o,
  .mem_we_o,
  .mem_addr_o,
  .mem_wdata_o,
  .mem_gnt_i,
  .mem_rvalid_i,
  .mem_rdata_i
);

`default_nettype wire

//--- verif/dma_core_tb.sv
/*
 * Testbench for dma_core_top. Jobs come from verif/dma_core_vectors.txt, opened
 * relative to the project root. Memory reads return word address XOR A5A50000.
 * Writes are only logged, so overlapping jobs do not disturb each other.
 */
`timescale 1ns/10ps
`default_nettype none

module dma_core_tb;
  import dma_pkg::*;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned JobFifoDepth = 4;

  logic                 clk;
  logic                 arst_n;
  logic                 reg_req;
  logic                 reg_we;
  logic [3:0]           reg_addr;
  logic [DataWidth-1:0] reg_wdata;
  logic [DataWidth-1:0] reg_rdata;
  logic                 reg_ready;
  logic                 mem_req;
  logic                 mem_we;
  logic [AddrWidth-1:0] mem_addr;
  logic [DataWidth-1:0] mem_wdata;
  logic                 mem_gnt;
  logic                 mem_rvalid;
  logic [DataWidth-1:0] mem_rdata;

  logic [AddrWidth-1:0] vec_src[$];
  logic [AddrWidth-1:0] vec_dst[$];
  logic [AddrWidth-1:0] vec_len[$];
  logic [AddrWidth-1:0] vec_sstr[$];
  logic [AddrWidth-1:0] vec_dstr[$];
  logic [AddrWidth-1:0] vec_reps[$];
  logic [AddrWidth-1:0] log_addr[$];
  logic [DataWidth-1:0] log_data[$];
  logic [AddrWidth-1:0] exp_addr[$];
  logic [DataWidth-1:0] exp_data[$];

  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  int                   launched;
  int                   wd_cycles;
  logic                 stall_all;
  logic [7:0]           lfsr_q;
  logic                 take_rd;
  logic [AddrWidth-1:0] take_addr;

  dma_core_top #(
    .AddrWidth    ( AddrWidth    ),
    .DataWidth    ( DataWidth    ),
    .JobFifoDepth ( JobFifoDepth )
  ) u_dma_core_top (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .reg_req_i    ( reg_req    ),
    .reg_we_i     ( reg_we     ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .reg_rdata_o  ( reg_rdata  ),
    .reg_ready_o  ( reg_ready  ),
    .mem_req_o    ( mem_req    ),
    .mem_we_o     ( mem_we     ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  )
  );

  always #10 clk = ~clk;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [DataWidth-1:0] mem_word(logic [AddrWidth-1:0] addr);
    return DataWidth'(addr >> 2) ^ 32'hA5A5_0000;
  endfunction

  // Samples the port at the falling edge, answers 2 ns after the rising edge
  always begin : mem_model
    @(negedge clk);
    take_rd   = mem_req && mem_gnt && !mem_we;
    take_addr = mem_addr;
    if (mem_req && mem_gnt && mem_we) begin
      log_addr.push_back(mem_addr);
      log_data.push_back(mem_wdata);
    end
    @(posedge clk);
    #2;
    mem_rvalid = take_rd;
    mem_rdata  = take_rd ? mem_word(take_addr) : '0;
    lfsr_q     = lfsr_step(lfsr_q);
    mem_gnt    = !stall_all && lfsr_q[0];
  end

  task automatic check_word(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input logic [JobIdWidth-1:0] got, input logic [JobIdWidth-1:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // Called 2 ns after a rising edge, returns at the same phase
  task automatic reg_access(input logic we, input dma_reg_e addr,
                            input logic [DataWidth-1:0] wdata,
                            output logic [DataWidth-1:0] rdata);
    logic done;
    reg_req   = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    done      = 1'b0;
    while (!done) begin
      @(negedge clk);
      done  = reg_ready;
      rdata = reg_rdata;
      @(posedge clk);
      #2;
    end
    reg_req = 1'b0;
  endtask

  task automatic set_stall(input logic value);
    @(negedge clk);
    stall_all = value;
    @(posedge clk);
    #2;
  endtask

  task automatic launch_job(input int idx);
    logic [DataWidth-1:0] rd;
    reg_access(1'b1, REG_SRC, vec_src[idx], rd);
    reg_access(1'b1, REG_DST, vec_dst[idx], rd);
    reg_access(1'b1, REG_LEN, vec_len[idx], rd);
    reg_access(1'b1, REG_SRC_STRIDE, vec_sstr[idx], rd);
    reg_access(1'b1, REG_DST_STRIDE, vec_dstr[idx], rd);
    reg_access(1'b1, REG_REPS, vec_reps[idx], rd);
    reg_access(1'b0, REG_NEXT_ID, '0, rd);
    launched++;
    check_id(rd[JobIdWidth-1:0], JobIdWidth'(launched), "NEXT_ID");
  endtask

  // Writes of repetition k, word i land at dst + k*dst_stride + 4i
  task automatic expect_job(input int idx);
    logic [AddrWidth-1:0] reps;
    logic [AddrWidth-1:0] src;
    logic [AddrWidth-1:0] dst;
    reps = (vec_reps[idx] == '0) ? AddrWidth'(1) : vec_reps[idx];
    for (int k = 0; k < reps; k++) begin
      for (int i = 0; i < vec_len[idx]; i++) begin
        src = vec_src[idx] + AddrWidth'(k) * vec_sstr[idx] + AddrWidth'(4 * i);
        dst = vec_dst[idx] + AddrWidth'(k) * vec_dstr[idx] + AddrWidth'(4 * i);
        exp_addr.push_back(dst);
        exp_data.push_back(mem_word(src));
      end
    end
  endtask

  // Polls until the count reaches the launched jobs, an overshoot shows up as an error
  task automatic wait_done();
    logic [DataWidth-1:0] rd;
    rd = '0;
    while (rd[JobIdWidth-1:0] < JobIdWidth'(launched)) begin
      reg_access(1'b0, REG_DONE_ID, '0, rd);
    end
    check_id(rd[JobIdWidth-1:0], JobIdWidth'(launched), "DONE_ID");
  endtask

  task automatic compare_log();
    check_word(DataWidth'(log_addr.size()), DataWidth'(exp_addr.size()), "write count");
    for (int n = 0; n < exp_addr.size() && n < log_addr.size(); n++) begin
      check_word(log_addr[n], exp_addr[n], $sformatf("write %0d address", n));
      check_word(log_data[n], exp_data[n], $sformatf("write %0d data", n));
    end
    log_addr.delete();
    log_data.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("TEST %s: passed", name);
    end else begin
      tests_failed++;
      $display("TEST %s: FAILED", name);
    end
  endtask

  initial begin : watchdog
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: the DMA did not finish its jobs within %0d cycles", wd_cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    int                   fd;
    int                   n;
    int                   errs_before;
    int                   assert_fails;
    longint               total;
    logic [8*160-1:0]     line;
    logic [AddrWidth-1:0] f [6];
    logic [DataWidth-1:0] rd;
    string                name;
    clk        = 1'b0;
    arst_n     = 1'b0;
    reg_req    = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = REG_SRC;
    reg_wdata  = '0;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    stall_all  = 1'b0;
    lfsr_q     = 8'd79;
    errors     = 0;
    launched   = 0;
    total      = 0;
    fd = $fopen("verif/dma_core_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file verif/dma_core_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
          if (n == 6) begin
            vec_src.push_back(f[0]);
            vec_dst.push_back(f[1]);
            vec_len.push_back(f[2]);
            vec_sstr.push_back(f[3]);
            vec_dstr.push_back(f[4]);
            vec_reps.push_back(f[5]);
            total += f[2] * ((f[5] == '0) ? 1 : f[5]) * 40 + 100;
          end
        end
      end
      $fclose(fd);
    end
    if (vec_src.size() < JobFifoDepth + 1) begin
      $display("The vector file holds %0d jobs, too few for the queueing test", vec_src.size());
      errors++;
    end

    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;

    if (errors == 0) begin
      // Each job runs twice at most, once alone and once queued
      wd_cycles = int'(2 * total + 2000);
      for (int v = 0; v < vec_src.size(); v++) begin
        errs_before = errors;
        expect_job(v);
        launch_job(v);
        wait_done();
        compare_log();
        if (vec_len[v] == '0) begin
          name = "zero-length";
        end else if (vec_reps[v] <= 1) begin
          name = "1d copy";
        end else begin
          name = "2d copy";
        end
        finish_test($sformatf("%s, job %0d", name, v), errs_before);
      end

      errs_before = errors;
      reg_access(1'b0, REG_DONE_ID, '0, rd);
      check_id(rd[JobIdWidth-1:0], JobIdWidth'(launched), "DONE_ID");
      finish_test("job identifiers", errs_before);

      // Backend sits in READ while the FIFO fills up
      errs_before = errors;
      set_stall(1'b1);
      for (int v = 0; v < JobFifoDepth + 1; v++) begin
        expect_job(v);
        launch_job(v);
      end
      reg_access(1'b0, REG_STATUS, '0, rd);
      check_word(rd, DataWidth'(1), "STATUS while stalled");
      set_stall(1'b0);
      wait_done();
      compare_log();
      reg_access(1'b0, REG_STATUS, '0, rd);
      check_word(rd, '0, "STATUS");
      finish_test("queued jobs under stalls", errs_before);
    end

    assert_fails = u_dma_core_top.u_dma_core_assert.fail_count;
    $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && tests_failed == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : dma_core_tb

`default_nettype wire

//--- verif/dma_core_vectors.txt
# src dst len src_stride dst_stride reps, all hex, one job per line
# len counts 32-bit words, reps 0 runs once
1000 8000 4 0 0 1
2000 9000 3 40 80 3
3000 a000 0 0 0 1
4000 b000 1 10 20 4
5000 c000 8 0 0 0
6000 d000 2 100 8 5
7000 e000 0 40 40 3
8000 f000 5 20 40 2
0 10000 6 0 0 1
ffc 11000 2 4 8 2
12000 12000 3 c 0 2
fffffff0 13000 4 0 0 1
14000 20000 10 0 0 1
15000 21000 1 4 4 8
16000 22000 7 100 200 3
17000 23000 2 fffffff8 8 3
